/* list.f */
src/alut_pkg.sv
src/alut_mem.sv
src/alut_addr_check.sv
src/alut_age_check.sv
src/alut_top.sv
verification/alut_clk_gen.sv
verification/alut_tb.sv

/* Makefile */
# Verilator build for the alut MAC table and its testbench

TOP = alut_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only src/alut_pkg.sv src/alut_mem.sv src/alut_addr_check.sv \
		src/alut_age_check.sv src/alut_top.sv --top-module alut_top
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/alut_tb.sv */
/*
 * alut testbench
 * table of learn/lookup rows with expected hit and port, aging and back-pressure
 */
`timescale 1ns/1ns

module alut_tb;
   import alut_pkg::*;

   typedef struct packed
   {
      alut_op_e    op;
      mac_t        mac;
      port_t       port;
      logic        age_en;
      stamp_t      age_limit;
      logic [15:0] idle_wait;   // cycles before the request
      logic [15:0] stall;       // rsp_ready held low this long
      logic        rnd_stall;   // stall drawn from $random instead
      logic        exp_hit;
      port_t       exp_port;
   } row_t;

   localparam mac_t mac_a = 48'h00_1a_2b_3c_4d_5e;
   localparam mac_t mac_b = 48'h02_00_00_00_00_01;
   localparam mac_t mac_d = 48'h0a_0b_0c_0d_0e_0f;
   localparam mac_t mac_e = 48'hde_ad_be_ef_00_01;
   localparam mac_t mac_f = 48'h00_00_00_00_00_77;
   localparam stamp_t big_limit = 32'h0010_0000;

   logic      pclk26, arst_n;
   alut_req_t req;
   logic      req_valid, req_ready;
   alut_rsp_t rsp;
   logic      rsp_valid, rsp_ready;
   logic      age_en;
   stamp_t    age_limit;

   mac_t      mac_c;        // other mac in the slot of mac_a
   row_t      rows [$];
   int        errors, passed, budget;
   integer    seed;

   alut_clk_gen i_alut_clk_gen (.pclk26, .arst_n);

   alut_top i_alut_top
   (
      .pclk26, .arst_n,
      .req, .req_valid, .req_ready,
      .rsp, .rsp_valid, .rsp_ready,
      .age_en, .age_limit
   );

   function automatic row_t make_row(input alut_op_e op, input mac_t mac, input port_t port,
                                     input logic en, input stamp_t lim, input int idle_wait,
                                     input int stall, input logic rnd, input logic hit,
                                     input port_t eport);
      return '{op, mac, port, en, lim, 16'(idle_wait), 16'(stall), rnd, hit, eport};
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // ----------------------------------------------------------------------
   // stimulus table
   // ----------------------------------------------------------------------
   task automatic build_table();
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 0, 0, 0, 0, 0));   // cleared table
      rows.push_back(make_row(op_learn,  mac_a, 2, 0, 50, 3, 0, 0, 0, 2));
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 0, 0, 0, 1, 2));
      rows.push_back(make_row(op_learn,  mac_a, 1, 0, 50, 0, 2, 0, 1, 1));   // relearn, new port
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 1, 0, 0, 1, 1));
      rows.push_back(make_row(op_learn,  mac_b, 3, 0, 50, 0, 0, 0, 0, 3));
      rows.push_back(make_row(op_learn,  mac_c, 0, 0, 50, 0, 0, 0, 0, 0));   // evicts mac_a
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 0, 0, 0, 0, 0));   // port of mac_c
      rows.push_back(make_row(op_lookup, mac_c, 0, 0, 50, 0, 0, 0, 1, 0));
      rows.push_back(make_row(op_lookup, mac_b, 0, 0, 50, 0, 0, 0, 1, 3));
      // aging
      rows.push_back(make_row(op_learn,  mac_d, 2, 0, 50, 0, 0, 0, 0, 2));
      rows.push_back(make_row(op_lookup, mac_d, 0, 0, 50, 200, 0, 0, 1, 2)); // aging off
      rows.push_back(make_row(op_lookup, mac_d, 0, 1, 50, 650, 0, 0, 0, 0)); // swept out
      rows.push_back(make_row(op_learn,  mac_e, 1, 1, big_limit, 0, 0, 0, 0, 1));
      rows.push_back(make_row(op_lookup, mac_e, 0, 1, big_limit, 0, 0, 0, 1, 1));
      // back-pressure
      rows.push_back(make_row(op_learn,  mac_f, 3, 0, 50, 0, 0, 1, 0, 3));
      rows.push_back(make_row(op_lookup, mac_f, 0, 0, 50, 0, 0, 1, 1, 3));
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 0, 0, 1, 0, 0));   // aged with the rest
      rows.push_back(make_row(op_learn,  mac_a, 2, 0, 50, 0, 5, 0, 0, 2));
      rows.push_back(make_row(op_lookup, mac_a, 0, 0, 50, 0, 0, 1, 1, 2));
      rows.push_back(make_row(op_lookup, mac_e, 0, 0, 50, 2, 0, 1, 1, 1));
   endtask

   // one request, one response, inputs change on the falling edge only
   task automatic run_row(input int idx, input row_t r);
      int        err_before;
      int        lat;
      int        stall;
      alut_rsp_t held;
      err_before = errors;
      stall      = r.rnd_stall ? ($random(seed) & 15) : int'(r.stall);
      age_en     = r.age_en;
      age_limit  = r.age_limit;
      repeat (int'(r.idle_wait)) @(negedge pclk26);
      req.op    = r.op;
      req.mac   = r.mac;
      req.port  = r.port;
      req_valid = 1'b1;
      while (!req_ready)
         @(negedge pclk26);
      @(negedge pclk26);                          // accepted on the edge before
      req_valid = 1'b0;
      check_val("req_ready", 64'(req_ready), 64'(1'b0));
      lat = 0;
      while (!rsp_valid && lat < 20)
      begin
         @(negedge pclk26);
         lat++;
      end
      if (!rsp_valid)
      begin
         $display("row %0d: no response within 20 cycles of acceptance", idx);
         errors++;
      end
      else
      begin
         check_val("rsp latency", 64'(lat), 64'(3));
         held = rsp;
         repeat (stall)
         begin
            @(negedge pclk26);
            check_val("rsp_valid", 64'(rsp_valid), 64'(1'b1));   // held under stall
            check_val("rsp", 64'(rsp), 64'(held));
            check_val("req_ready", 64'(req_ready), 64'(1'b0));
         end
         rsp_ready = 1'b1;
         @(negedge pclk26);
         rsp_ready = 1'b0;
         check_val("rsp_valid", 64'(rsp_valid), 64'(1'b0));      // exactly one response
         check_val("rsp.hit", 64'(held.hit), 64'(r.exp_hit));
         check_val("rsp.port", 64'(held.port), 64'(r.exp_port));
      end
      if (errors == err_before)
         passed++;
      $display("row %0d %s mac %012h stall %0d: %s", idx,
               (r.op == op_learn) ? "learn" : "lookup", r.mac, stall,
               (errors == err_before) ? "ok" : "failed");
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int init_wait;
      int init_err;
      int cycles;
      req       = '0;
      req_valid = 1'b0;
      rsp_ready = 1'b0;
      age_en    = 1'b0;
      age_limit = '0;
      errors    = 0;
      passed    = 0;
      seed      = 26;
      mac_c      = {mac_a[47:16], 16'hc3_00};
      mac_c[7:0] = alut_hash(mac_a) ^ alut_hash(mac_c);   // low byte evens out the fold
      build_table();
      cycles = 300;                                       // reset and clear sweep
      foreach (rows[i])
         cycles += int'(rows[i].idle_wait) + 20
                   + (rows[i].rnd_stall ? 16 : int'(rows[i].stall));
      budget = cycles;

      wait (arst_n === 1'b1);
      @(negedge pclk26);
      init_err = errors;
      check_val("req_ready", 64'(req_ready), 64'(1'b0));           // clear sweep running
      init_wait = 0;
      while (!req_ready && init_wait < 300)
      begin
         @(negedge pclk26);
         init_wait++;
      end
      if (!req_ready)
      begin
         $display("init: req_ready still low 300 cycles after reset");
         errors++;
      end
      if (errors == init_err)
         passed++;
      $display("init: ready after %0d cycles: %s", init_wait,
               (errors == init_err) ? "ok" : "failed");

      foreach (rows[i])
         run_row(i, rows[i]);

      $display("tests passed %0d of %0d, errors %0d", passed, rows.size() + 1, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // watchdog, budget set once the table is known
   initial
   begin
      wait (budget > 0);
      repeat (budget) @(posedge pclk26);
      $display("watchdog: run did not finish within %0d cycles", budget);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* verification/alut_clk_gen.sv */
/*
 * alut testbench clock and reset
 * pclk26 at 8 ns, arst_n held low for the first 5 cycles
 */
`timescale 1ns/1ns

module alut_clk_gen
(
   output logic pclk26,
   output logic arst_n
);

   initial
   begin
      pclk26 = 1'b0;
      forever #4 pclk26 = ~pclk26;   // 8 ns period
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (5) @(posedge pclk26);
      @(negedge pclk26);             // release away from the rising edge
      arst_n = 1'b1;
   end

endmodule

/* src/alut_top.sv */
/*
 * alut top level
 * address checker on ram port a, age checker on ram port b
 */
`timescale 1ns/1ns

module alut_top
(
   input  logic                pclk26,
   input  logic                arst_n,
   // request channel
   input  alut_pkg::alut_req_t req,
   input  logic                req_valid,
   output logic                req_ready,
   // response channel
   output alut_pkg::alut_rsp_t rsp,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   // aging config
   input  logic                age_en,
   input  alut_pkg::stamp_t    age_limit
);
   import alut_pkg::*;

   hash_t       addr_a, addr_b;
   logic        we_a, we_b;
   alut_entry_t wdata_a, wdata_b;
   alut_entry_t rdata_a, rdata_b;

   stamp_t      now;          // time base for learn stamps
   logic        init_done;    // clear sweep finished
   logic        busy;         // lookup/learn in flight, pauses aging

   // ----------------------------------------------------------------------
   alut_mem i_alut_mem
   (
      .pclk26  (pclk26),
      .addr_a  (addr_a),
      .we_a    (we_a),
      .wdata_a (wdata_a),
      .rdata_a (rdata_a),
      .addr_b  (addr_b),
      .we_b    (we_b),
      .wdata_b (wdata_b),
      .rdata_b (rdata_b)
   );

   alut_addr_check i_alut_addr_check
   (
      .pclk26, .arst_n,
      .req, .req_valid, .req_ready,
      .rsp, .rsp_valid, .rsp_ready,
      .init_done, .now, .busy,
      .addr_a, .we_a, .wdata_a, .rdata_a
   );

   alut_age_check i_alut_age_check
   (
      .pclk26, .arst_n,
      .age_en, .age_limit, .busy,
      .now, .init_done,
      .addr_b, .we_b, .wdata_b, .rdata_b
   );

endmodule

/* src/alut_age_check.sv */
/*
 * alut age checker
 * time stamp counter, clears the table after reset, then ages out old entries
 */
`timescale 1ns/1ns

module alut_age_check
(
   input  logic                  pclk26,
   input  logic                  arst_n,
   input  logic                  age_en,
   input  alut_pkg::stamp_t      age_limit,
   input  logic                  busy,       // address checker has a request
   output alut_pkg::stamp_t      now,
   output logic                  init_done,
   // ram port b
   output alut_pkg::hash_t       addr_b,
   output logic                  we_b,
   output alut_pkg::alut_entry_t wdata_b,
   input  alut_pkg::alut_entry_t rdata_b
);
   import alut_pkg::*;

   typedef enum logic [2:0]
   {
      clear,        // reset sweep, one slot per cycle
      idle,         // aging off
      read,         // read issued for sweep_idx
      wait_data,    // parked while busy, slot gets re-read
      judge         // data back, drop it if too old
   } age_state_e;

   age_state_e state;
   hash_t      sweep_idx;    // slot under test
   stamp_t     age;          // modulo age of the entry read
   logic       expired;

   assign age     = now - rdata_b.stamp;
   assign expired = rdata_b.valid && (age > age_limit);

   assign addr_b  = sweep_idx;
   assign wdata_b = '0;                        // invalid entry
   assign we_b    = (state == clear) || ((state == judge) && !busy && expired);

   // free running time base
   always_ff @(posedge pclk26 or negedge arst_n)
   begin
      if (!arst_n)
         now <= '0;
      else
         now <= now + 1'b1;
   end

   // ----------------------------------------------------------------------
   // sweep fsm
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk26 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= idle;
         sweep_idx <= '0;
         init_done <= 1'b0;
      end
      else
      begin
         case (state)
            clear:
            begin
               sweep_idx <= sweep_idx + 1'b1;   // wraps back to 0
               if (sweep_idx == hash_t'(alut_depth - 1))
               begin
                  init_done <= 1'b1;
                  state     <= idle;
               end
            end
            idle:
            begin
               if (!init_done)
                  state <= clear;               // first cycle out of reset
               else if (age_en && !busy)
                  state <= read;
            end
            read:      state <= busy ? wait_data : judge;
            wait_data:
            begin
               if (!busy)
                  state <= age_en ? read : idle;   // old data is stale
            end
            judge:
            begin
               if (busy)
                  state <= wait_data;           // no write, redo this slot
               else
               begin
                  sweep_idx <= sweep_idx + 1'b1;
                  state     <= age_en ? read : idle;
               end
            end
            default:   state <= idle;
         endcase
      end
   end

endmodule

/* src/alut_addr_check.sv */
/*
 * alut address checker
 * one learn or lookup at a time: hash, read slot, compare, write back on learn
 */
`timescale 1ns/1ns

module alut_addr_check
(
   input  logic                  pclk26,
   input  logic                  arst_n,
   // request channel
   input  alut_pkg::alut_req_t   req,
   input  logic                  req_valid,
   output logic                  req_ready,
   // response channel
   output alut_pkg::alut_rsp_t   rsp,
   output logic                  rsp_valid,
   input  logic                  rsp_ready,
   // from / to age checker
   input  logic                  init_done,
   input  alut_pkg::stamp_t      now,
   output logic                  busy,
   // ram port a
   output alut_pkg::hash_t       addr_a,
   output logic                  we_a,
   output alut_pkg::alut_entry_t wdata_a,
   input  alut_pkg::alut_entry_t rdata_a
);
   import alut_pkg::*;

   typedef enum logic [2:0]
   {
      idle,          // waiting for a request
      read,          // slot read issued
      wait_data,     // ram output valid
      resolve,       // compare, write back on learn
      respond        // hold rsp until taken
   } addr_state_e;

   addr_state_e state;
   alut_req_t   req_q;        // accepted request
   logic        accept;       // req transfer this edge
   logic        hit;          // slot holds the request mac
   logic        is_learn;

   // ----------------------------------------------------------------------
   // handshakes
   // ----------------------------------------------------------------------
   assign req_ready = init_done && (state == idle);   // table must be cleared first
   assign accept    = req_valid && req_ready;
   assign busy      = (state != idle);                // acceptance to rsp transfer

   // ----------------------------------------------------------------------
   // ram port a
   // ----------------------------------------------------------------------
   assign is_learn = (req_q.op == op_learn);
   assign addr_a   = alut_hash(req_q.mac);            // same slot all the way through
   assign we_a     = (state == resolve) && is_learn;

   always_comb
   begin
      wdata_a       = '0;
      wdata_a.valid = 1'b1;
      wdata_a.mac   = req_q.mac;
      wdata_a.port  = req_q.port;
      wdata_a.stamp = now;                             // age starts at this learn
   end

   assign hit = rdata_a.valid && (rdata_a.mac == req_q.mac);

   // ----------------------------------------------------------------------
   // control fsm
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk26 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= idle;
         rsp_valid <= 1'b0;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (accept)
                  state <= read;
            end
            read:      state <= wait_data;   // ram samples addr_a here
            wait_data: state <= resolve;     // rdata_a now holds the slot
            resolve:
            begin
               rsp_valid <= 1'b1;            // 3 cycles after accept
               state     <= respond;
            end
            respond:
            begin
               if (rsp_ready)
               begin
                  rsp_valid <= 1'b0;
                  state     <= idle;
               end
            end
            default:   state <= idle;
         endcase
      end
   end

   // payload registers
   always_ff @(posedge pclk26)
   begin
      if (accept)
         req_q <= req;                      // held until next accept
      if (state == resolve)
      begin
         rsp.hit  <= hit;                   // learn: mac was already known
         rsp.port <= is_learn ? req_q.port : rdata_a.port;
      end
   end

endmodule

/* src/alut_mem.sv */
/*
 * alut table ram
 * 256 x 83 two-port array, registered reads, port a wins a write clash
 */
`timescale 1ns/1ns

module alut_mem
(
   input  logic                 pclk26,
   // port a, address checker side
   input  alut_pkg::hash_t      addr_a,
   input  logic                 we_a,
   input  alut_pkg::alut_entry_t wdata_a,
   output alut_pkg::alut_entry_t rdata_a,
   // port b, age checker side
   input  alut_pkg::hash_t      addr_b,
   input  logic                 we_b,
   input  alut_pkg::alut_entry_t wdata_b,
   output alut_pkg::alut_entry_t rdata_b
);
   import alut_pkg::*;

   alut_entry_t mem_array [alut_depth];   // the lookup table itself

   logic        clash;                    // both ports write one slot

   assign clash = we_a && we_b && (addr_a == addr_b);

   // ----------------------------------------------------------------------
   // each port either writes or reads into its output register
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk26)
   begin
      if (we_a)
         mem_array[addr_a] <= wdata_a;    // learn write-back
      else
         rdata_a <= mem_array[addr_a];    // data one cycle later

      if (!we_b)
         rdata_b <= mem_array[addr_b];
      else if (!clash)                    // port a keeps the slot
         mem_array[addr_b] <= wdata_b;    // clear / age-out
   end

endmodule

/* src/alut_pkg.sv */
/*
 * alut shared definitions
 * widths, table entry, request/response types and the slot hash
 */
package alut_pkg;

   // ----------------------------------------------------------------------
   // sizes
   // ----------------------------------------------------------------------
   localparam int alut_depth = 256;    // table entries
   localparam int mac_bytes  = 6;      // bytes folded by the hash

   typedef logic [7:0]  hash_t;        // table index
   typedef logic [47:0] mac_t;         // ethernet mac
   typedef logic [1:0]  port_t;        // switch port, 4 ports
   typedef logic [31:0] stamp_t;       // pclk26 cycles, wraps

   // ----------------------------------------------------------------------
   // table entry, 83 bits like the ram data bus
   // ----------------------------------------------------------------------
   typedef struct packed
   {
      logic   valid;                   // slot in use
      mac_t   mac;                     // learned source mac
      port_t  port;                    // ingress port it came in on
      stamp_t stamp;                   // time of last learn
   } alut_entry_t;

   typedef enum logic
   {
      op_lookup,                       // find egress port
      op_learn                         // store mac/port/time
   } alut_op_e;

   typedef struct packed
   {
      alut_op_e op;
      mac_t     mac;
      port_t    port;                  // ignored on lookup
   } alut_req_t;

   typedef struct packed
   {
      logic  hit;                      // mac found in its slot
      port_t port;
   } alut_rsp_t;

   // xor-fold the six mac bytes into one slot index
   function automatic hash_t alut_hash(input mac_t mac);
      hash_t h;
      h = '0;
      for (int i = 0; i < mac_bytes; i++)
      begin
         h = h ^ mac[8*i +: 8];        // fold byte i
      end
      return h;
   endfunction

endpackage
